// ==== include/dqmAddressMap.svh ====
`ifndef DQM_ADDRESS_MAP_SVH
`define DQM_ADDRESS_MAP_SVH

// ##############################
// APB register offsets
// ##############################

// bit 0 enables buffer, divider and framer
`define DQM_REG_CTRL    8'h00
// DQM word placed in the low 16 header bits
`define DQM_REG_DQM     8'h04
// payload bits per block minus one
`define DQM_REG_SIZE    8'h08
// clocks per output bit minus one
`define DQM_REG_RATE    8'h0C
// bit 0 sticky overrun (write 1 clears), bit 1 framer busy
`define DQM_REG_STATUS  8'h10

`endif

// ==== design/dqmPkg.sv ====
package dqmPkg;

    // ##############################
    // widths
    // ##############################

    localparam int DQM_HEADER_BITS = 48;

    typedef logic [15:0] dqmWord;
    // block length minus one
    typedef logic [13:0] blockLen;
    // clocks per output bit minus one
    typedef logic [15:0] bitPeriod;
    typedef logic [DQM_HEADER_BITS-1:0] headerWord;
    typedef logic [7:0] apbAddr;
    typedef logic [31:0] apbData;

    // ##############################
    // header fields
    // ##############################

    localparam logic [15:0] DQM_SYNC_WORD = 16'hFAF3;
    localparam logic [3:0] DQM_VERSION = 4'h4;

    // one bank holds the largest block
    localparam int BANK_DEPTH = 16384;

    // align waits for the bit strobe before the first header bit
    typedef enum logic [1:0] {
        idle,
        align,
        header,
        payload
    } framerState;

endpackage

// ==== design/dqmApbRegs.sv ====
`timescale 1ns/1ps
`include "dqmAddressMap.svh"

module dqmApbRegs (
    input  logic             clk,
    input  logic             reset,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  dqmPkg::apbAddr   paddr,
    input  dqmPkg::apbData   pwdata,
    output dqmPkg::apbData   prdata,
    output logic             pready,
    output logic             pslverr,
    input  logic             overrunPulse,
    input  logic             framerBusy,
    output logic             enable,
    output dqmPkg::dqmWord   dqmValue,
    output dqmPkg::blockLen  payloadSize,
    output dqmPkg::bitPeriod clksPerBit
);
    import dqmPkg::*;

    logic writeAccess;
    logic overrunClear;
    logic overrunFlag;

    // no wait states, no error responses
    assign pready = 1'b1;
    assign pslverr = 1'b0;

    assign writeAccess = psel && penable && pready && pwrite;
    assign overrunClear = writeAccess && (paddr == `DQM_REG_STATUS) && pwdata[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            enable <= 1'b0;
            dqmValue <= '0;
            payloadSize <= '0;
            clksPerBit <= '0;
        end else if (writeAccess) begin
            case (paddr)
                `DQM_REG_CTRL: enable <= pwdata[0];
                `DQM_REG_DQM: dqmValue <= dqmWord'(pwdata);
                `DQM_REG_SIZE: payloadSize <= blockLen'(pwdata);
                `DQM_REG_RATE: clksPerBit <= bitPeriod'(pwdata);
                default: ;
            endcase
        end
    end

    // a new overrun wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            overrunFlag <= 1'b0;
        end else if (overrunPulse) begin
            overrunFlag <= 1'b1;
        end else if (overrunClear) begin
            overrunFlag <= 1'b0;
        end
    end

    always_comb begin
        prdata = '0;
        case (paddr)
            `DQM_REG_CTRL: prdata[0] = enable;
            `DQM_REG_DQM: prdata[15:0] = dqmValue;
            `DQM_REG_SIZE: prdata[13:0] = payloadSize;
            `DQM_REG_RATE: prdata[15:0] = clksPerBit;
            `DQM_REG_STATUS: prdata[1:0] = {framerBusy, overrunFlag};
            default: prdata = '0;
        endcase
    end

    // setup phase is always followed by its access phase
    apbSetupAccess: assert property (@(posedge clk) disable iff (reset)
        psel && !penable |=> psel && penable && $stable(paddr) && $stable(pwrite));

endmodule

// ==== design/dqmBitBuffer.sv ====
`timescale 1ns/1ps

module dqmBitBuffer (
    input  logic            clk,
    input  logic            reset,
    input  logic            enable,
    input  dqmPkg::blockLen payloadSize,
    input  logic            payloadBit,
    input  logic            payloadBitEn,
    output logic            blockReady,
    output logic            readyBank,
    input  logic            framerBusy,
    output logic            overrunPulse,
    input  logic            readEn,
    input  logic            readBank,
    output logic            payloadBitOut
);
    import dqmPkg::*;

    logic bank0 [BANK_DEPTH];
    logic bank1 [BANK_DEPTH];

    logic    writeBank;
    blockLen writeCount;
    blockLen readPtr [2];
    logic    bitWrite;
    logic    accepted;

    assign bitWrite = enable && payloadBitEn;

    // last bit of a block goes in this cycle
    assign blockReady = bitWrite && (writeCount == payloadSize);
    assign readyBank = writeBank;
    assign overrunPulse = blockReady && framerBusy;
    assign accepted = blockReady && !framerBusy;

    // ##############################
    // write side
    // ##############################

    // on overrun the bank is kept, so the dropped block gets overwritten
    // and the bank being read is never touched
    always_ff @(posedge clk) begin
        if (reset) begin
            writeCount <= '0;
            writeBank <= 1'b0;
            readPtr[0] <= '0;
            readPtr[1] <= '0;
        end else begin
            if (!enable) begin
                writeCount <= '0;
            end else if (payloadBitEn) begin
                writeCount <= blockReady ? '0 : writeCount + 1'b1;
            end
            if (accepted) begin
                writeBank <= ~writeBank;
                readPtr[writeBank] <= '0;
            end
            if (readEn) begin
                readPtr[readBank] <= readPtr[readBank] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bitWrite) begin
            if (writeBank) begin
                bank1[writeCount] <= payloadBit;
            end else begin
                bank0[writeCount] <= payloadBit;
            end
        end
    end

    // ##############################
    // read side
    // ##############################

    always_ff @(posedge clk) begin
        if (reset) begin
            payloadBitOut <= 1'b0;
        end else if (readEn) begin
            payloadBitOut <= readBank ? bank1[readPtr[1]] : bank0[readPtr[0]];
        end
    end

    // framer only reads the bank handed over at the last accepted block
    readOtherBank: assert property (@(posedge clk) disable iff (reset)
        readEn |-> readBank != writeBank);

endmodule

// ==== design/dqmFramer.sv ====
`timescale 1ns/1ps

module dqmFramer (
    input  logic             clk,
    input  logic             reset,
    input  logic             enable,
    input  dqmPkg::dqmWord   dqmValue,
    input  dqmPkg::blockLen  payloadSize,
    input  dqmPkg::bitPeriod clksPerBit,
    input  logic             blockReady,
    input  logic             readyBank,
    output logic             framerBusy,
    output logic             readEn,
    output logic             readBank,
    input  logic             payloadBitIn,
    output logic             dqmStartOfFrame,
    output logic             dqmBitEn,
    output logic             dqmBit
);
    import dqmPkg::*;

    framerState state;
    framerState nextState;
    bitPeriod   divCount;
    logic       strobe;
    logic       preStrobe;
    logic       accept;
    blockLen    bitCount;
    blockLen    frameSize;
    headerWord  headerSr;

    // ##############################
    // bit rate divider
    // ##############################

    always_ff @(posedge clk) begin
        if (reset || !enable) begin
            divCount <= '0;
        end else if (divCount == '0) begin
            divCount <= clksPerBit;
        end else begin
            divCount <= divCount - 1'b1;
        end
    end

    assign strobe = enable && (divCount == '0);
    // strobe follows in the next cycle
    assign preStrobe = enable && ((divCount == bitPeriod'(1)) || (clksPerBit == '0));

    // ##############################
    // frame sequencing
    // ##############################

    assign framerBusy = (state != idle);
    assign accept = blockReady && !framerBusy;

    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (accept) begin
                    nextState = preStrobe ? header : align;
                end
            end
            align: begin
                if (preStrobe) begin
                    nextState = header;
                end
            end
            header: begin
                if (strobe && (bitCount == blockLen'(DQM_HEADER_BITS - 1))) begin
                    nextState = payload;
                end
            end
            payload: begin
                if (strobe && (bitCount == frameSize)) begin
                    nextState = idle;
                end
            end
            default: nextState = idle;
        endcase
        if (!enable) begin
            nextState = idle;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
            bitCount <= '0;
            frameSize <= '0;
            readBank <= 1'b0;
            headerSr <= '0;
        end else begin
            state <= nextState;
            if (nextState != state) begin
                bitCount <= '0;
            end else if (dqmBitEn) begin
                bitCount <= bitCount + 1'b1;
            end
            if (accept) begin
                frameSize <= payloadSize;
                readBank <= readyBank;
                headerSr <= {DQM_SYNC_WORD, 12'h000, DQM_VERSION, dqmValue};
            end else if (strobe && (state == header)) begin
                headerSr <= {headerSr[DQM_HEADER_BITS-2:0], 1'b0};
            end
        end
    end

    // fetch each payload bit the cycle before its strobe
    assign readEn = preStrobe && (nextState == payload);

    assign dqmBitEn = strobe && ((state == header) || (state == payload));
    assign dqmBit = (state == payload) ? payloadBitIn : headerSr[DQM_HEADER_BITS-1];
    assign dqmStartOfFrame = dqmBitEn && (state == header) && (bitCount == '0);

    // the fetched bit goes out at the very next strobe
    readBeforeStrobe: assert property (@(posedge clk) disable iff (reset || !enable)
        readEn |=> dqmBitEn && (state == payload));

    // busy drops only right after the last payload bit went out
    busyEndsOnBit: assert property (@(posedge clk) disable iff (reset || !enable)
        $fell(framerBusy) |-> $past(dqmBitEn));

endmodule

// ==== design/dqmTelemetryTop.sv ====
`timescale 1ns/1ps

module dqmTelemetryTop (
    input  logic           clk,
    input  logic           reset,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  dqmPkg::apbAddr paddr,
    input  dqmPkg::apbData pwdata,
    output dqmPkg::apbData prdata,
    output logic           pready,
    output logic           pslverr,
    input  logic           payloadBit,
    input  logic           payloadBitEn,
    output logic           dqmStartOfFrame,
    output logic           dqmBitEn,
    output logic           dqmBit
);
    import dqmPkg::*;

    logic     enable;
    dqmWord   dqmValue;
    blockLen  payloadSize;
    bitPeriod clksPerBit;
    logic     overrunPulse;
    logic     framerBusy;
    logic     blockReady;
    logic     readyBank;
    logic     readEn;
    logic     readBank;
    logic     payloadBitOut;

    dqmApbRegs regs (
        .clk(clk),
        .reset(reset),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .overrunPulse(overrunPulse),
        .framerBusy(framerBusy),
        .enable(enable),
        .dqmValue(dqmValue),
        .payloadSize(payloadSize),
        .clksPerBit(clksPerBit)
    );

    dqmBitBuffer buffer (
        .clk(clk),
        .reset(reset),
        .enable(enable),
        .payloadSize(payloadSize),
        .payloadBit(payloadBit),
        .payloadBitEn(payloadBitEn),
        .blockReady(blockReady),
        .readyBank(readyBank),
        .framerBusy(framerBusy),
        .overrunPulse(overrunPulse),
        .readEn(readEn),
        .readBank(readBank),
        .payloadBitOut(payloadBitOut)
    );

    dqmFramer framer (
        .clk(clk),
        .reset(reset),
        .enable(enable),
        .dqmValue(dqmValue),
        .payloadSize(payloadSize),
        .clksPerBit(clksPerBit),
        .blockReady(blockReady),
        .readyBank(readyBank),
        .framerBusy(framerBusy),
        .readEn(readEn),
        .readBank(readBank),
        .payloadBitIn(payloadBitOut),
        .dqmStartOfFrame(dqmStartOfFrame),
        .dqmBitEn(dqmBitEn),
        .dqmBit(dqmBit)
    );

endmodule

// ==== sim/tbDqmTelemetry.sv ====
`timescale 1ns/1ps
`include "dqmAddressMap.svh"

module tbDqmTelemetry;
    import dqmPkg::*;

    localparam int HEADER_BITS = 48;
    localparam int APB_LIMIT = 16;

    logic   clk;
    logic   reset;
    logic   psel;
    logic   penable;
    logic   pwrite;
    apbAddr paddr;
    apbData pwdata;
    apbData prdata;
    logic   pready;
    logic   pslverr;
    logic   payloadBit;
    logic   payloadBitEn;
    logic   dqmStartOfFrame;
    logic   dqmBitEn;
    logic   dqmBit;

    logic   outBits [$];
    int     outStamps [$];
    int     cycle;
    int     startStamp;
    int     frameCount;
    int     framesExpected;
    int     frameNo;
    int     blockBits;
    int     rate;
    integer seed;

    dqmTelemetryTop i_dqmTelemetryTop (
        .clk(clk),
        .reset(reset),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .payloadBit(payloadBit),
        .payloadBitEn(payloadBitEn),
        .dqmStartOfFrame(dqmStartOfFrame),
        .dqmBitEn(dqmBitEn),
        .dqmBit(dqmBit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // serial output capture stamped with the cycle number
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!reset && dqmBitEn) begin
            outBits.push_back(dqmBit);
            outStamps.push_back(cycle);
        end
        if (!reset && dqmStartOfFrame) begin
            frameCount = frameCount + 1;
            startStamp = cycle;
        end
    end

    // ##############################
    // checking
    // ##############################

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch at %0t ns: %s expected %0h, got %0h",
                              $time, name, expected, actual));
        end
    endtask

    // ##############################
    // APB and payload drivers
    // ##############################

    task automatic apbWrite(input apbAddr addr, input apbData data);
        int tries;
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        tries = 0;
        do begin
            @(posedge clk);
            tries++;
            if (tries > APB_LIMIT)
                failRun($sformatf("APB write to %0h never completed", addr));
        end while (!pready);
        checkValue("pslverr", 0, pslverr);
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apbRead(input apbAddr addr, output apbData data);
        int tries;
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        @(negedge clk);
        penable = 1'b1;
        tries = 0;
        do begin
            @(posedge clk);
            tries++;
            if (tries > APB_LIMIT)
                failRun($sformatf("APB read from %0h never completed", addr));
        end while (!pready);
        data = prdata;
        checkValue("pslverr", 0, pslverr);
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    // first bit of a block is its msb
    // idle gaps stay below spacing
    task automatic feedBlock(input logic [63:0] data, input int spacing);
        int gap;
        for (int k = 0; k < blockBits; k++) begin
            @(negedge clk);
            payloadBit = data[blockBits-1-k];
            payloadBitEn = 1'b1;
            gap = ($random(seed) & 32'h7fff_ffff) % spacing;
            repeat (gap) begin
                @(negedge clk);
                payloadBitEn = 1'b0;
            end
        end
        @(negedge clk);
        payloadBitEn = 1'b0;
    endtask

    task automatic waitBits(input int total);
        int tries;
        tries = 0;
        while (outBits.size() < total) begin
            @(negedge clk);
            tries++;
            if (tries > (total + 2) * (rate + 1) + 64)
                failRun($sformatf("Timeout: frame %0d stalled after %0d of %0d output bits",
                                  frameNo, outBits.size(), total));
        end
    endtask

    task automatic waitIdle();
        apbData status;
        int tries;
        tries = 0;
        apbRead(`DQM_REG_STATUS, status);
        while (status[1]) begin
            tries++;
            if (tries > APB_LIMIT)
                failRun($sformatf("Timeout: framer still busy after frame %0d", frameNo));
            apbRead(`DQM_REG_STATUS, status);
        end
    endtask

    task automatic checkFrame(input headerWord header, input logic [63:0] data,
                              input apbData dqm);
        headerWord   gotHeader;
        logic [63:0] gotData;
        int          total;
        total = HEADER_BITS + blockBits;
        // sync word, twelve zeros, version, DQM word
        checkValue("golden header", {16'hFAF3, 12'h000, 4'h4, dqm[15:0]}, header);
        waitBits(total);
        waitIdle();
        gotHeader = '0;
        gotData = '0;
        for (int k = 0; k < HEADER_BITS; k++)
            gotHeader = {gotHeader[HEADER_BITS-2:0], outBits[k]};
        for (int k = 0; k < blockBits; k++)
            gotData = {gotData[62:0], outBits[HEADER_BITS+k]};
        checkValue("dqmBit header", header, gotHeader);
        checkValue("dqmBit payload", data & ((64'd1 << blockBits) - 1), gotData);
        for (int k = 1; k < total; k++)
            checkValue("dqmBitEn spacing", rate + 1, outStamps[k] - outStamps[k-1]);
        checkValue("dqmBitEn count", total, outBits.size());
        checkValue("dqmStartOfFrame count", framesExpected, frameCount);
        checkValue("dqmStartOfFrame cycle", outStamps[0], startStamp);
    endtask

    // ##############################
    // golden records
    // ##############################

    task automatic runLine(input logic [8*128-1:0] line);
        logic [8*8-1:0] tag;
        apbData         size;
        apbData         rateVal;
        apbData         dqm;
        apbData         rd;
        logic [63:0]    data;
        logic [63:0]    dropped;
        headerWord      header;
        int             fields;
        int             spacing;
        int             flag;
        tag = '0;
        if ($sscanf(line, "%s", tag) != 1)
            return;
        case (tag)
            "#": ;
            "cfg": begin
                fields = $sscanf(line, "%s %h %h", tag, size, rateVal);
                if (fields != 3)
                    failRun("malformed cfg record in golden file");
                apbWrite(`DQM_REG_SIZE, size);
                apbWrite(`DQM_REG_RATE, rateVal);
                apbWrite(`DQM_REG_CTRL, 32'h1);
                apbRead(`DQM_REG_SIZE, rd);
                checkValue("SIZE register", size, rd);
                apbRead(`DQM_REG_RATE, rd);
                checkValue("RATE register", rateVal, rd);
                apbRead(`DQM_REG_CTRL, rd);
                checkValue("CTRL register", 1, rd);
                blockBits = size + 1;
                rate = rateVal;
            end
            "frame", "ovr": begin
                if (tag == "frame") begin
                    fields = $sscanf(line, "%s %h %h %d %h", tag, dqm, data, spacing, header);
                end else begin
                    fields = $sscanf(line, "%s %h %h %h %h %d", tag, dqm, data, dropped,
                                     header, flag);
                end
                if (fields != (tag == "frame" ? 5 : 6))
                    failRun("malformed frame record in golden file");
                frameNo++;
                apbWrite(`DQM_REG_DQM, dqm);
                apbRead(`DQM_REG_DQM, rd);
                checkValue("DQM register", dqm, rd);
                outBits.delete();
                outStamps.delete();
                framesExpected++;
                if (tag == "frame") begin
                    feedBlock(data, spacing);
                    checkFrame(header, data, dqm);
                end else begin
                    // second block lands while the first is still being sent
                    feedBlock(data, 1);
                    feedBlock(dropped, 1);
                    apbRead(`DQM_REG_STATUS, rd);
                    checkValue("STATUS overrun", flag, rd[0]);
                    checkValue("STATUS busy", 1, rd[1]);
                    checkFrame(header, data, dqm);
                    apbWrite(`DQM_REG_STATUS, 32'h1);
                    apbRead(`DQM_REG_STATUS, rd);
                    checkValue("STATUS after clear", 0, rd);
                end
            end
            "off": begin
                fields = $sscanf(line, "%s %h %d", tag, data, spacing);
                if (fields != 3)
                    failRun("malformed off record in golden file");
                apbWrite(`DQM_REG_CTRL, 32'h0);
                apbRead(`DQM_REG_CTRL, rd);
                checkValue("CTRL register", 0, rd);
                outBits.delete();
                outStamps.delete();
                feedBlock(data, spacing);
                // watch for a whole frame time
                for (int k = 0; k < (HEADER_BITS + blockBits + 2) * (rate + 1); k++)
                    @(negedge clk);
                checkValue("dqmBitEn while disabled", 0, outBits.size());
                checkValue("dqmStartOfFrame count", framesExpected, frameCount);
                apbWrite(`DQM_REG_CTRL, 32'h1);
            end
            default: failRun("unknown record tag in golden file");
        endcase
    endtask

    initial begin
        logic [8*128-1:0] line;
        apbData           rd;
        int               fd;
        int               n;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        payloadBit = 1'b0;
        payloadBitEn = 1'b0;
        seed = 51;
        cycle = 0;
        startStamp = 0;
        frameCount = 0;
        framesExpected = 0;
        frameNo = 0;
        blockBits = 1;
        rate = 0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        apbRead(`DQM_REG_STATUS, rd);
        checkValue("STATUS after reset", 0, rd);
        fd = $fopen("sim/dqmGolden.txt", "r");
        if (fd == 0)
            failRun("could not open sim/dqmGolden.txt");
        while (!$feof(fd)) begin
            line = '0;
            n = $fgets(line, fd);
            if (n > 0)
                runLine(line);
        end
        $fclose(fd);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== dqmTelemetry.f ====
+incdir+include
design/dqmPkg.sv
design/dqmApbRegs.sv
design/dqmBitBuffer.sv
design/dqmFramer.sv
design/dqmTelemetryTop.sv
sim/tbDqmTelemetry.sv

// ==== Bender.yml ====
package:
  name: dqmTelemetry

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/dqmPkg.sv
      - design/dqmApbRegs.sv
      - design/dqmBitBuffer.sv
      - design/dqmFramer.sv
      - design/dqmTelemetryTop.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tbDqmTelemetry.sv

// ==== sim/dqmGolden.txt ====
# cfg <payloadSize hex> <clksPerBit hex>, frame <dqm> <block, first bit msb> <spacing dec> <header>
# ovr <dqm> <kept block> <dropped block> <header> <overrun flag dec>, off <block> <spacing dec>
cfg 00f 0001
frame 1a2b c3a5 3 faf300041a2b
frame 0001 ffff 1 faf300040001
frame 8000 0f0f 4 faf300048000
frame beef 5a3c 2 faf30004beef
frame 0000 0001 3 faf300040000
ovr 2468 a5a5 5a5a faf300042468 1
frame 1357 8001 2 faf300041357
off 9bd7 2
frame 4242 00ff 1 faf300044242
cfg 01f 0003
frame 7e81 deadbeef 2 faf300047e81
frame 0000 12345678 5 faf300040000
frame ffff 0f1e2d3c 3 faf30004ffff
frame c0de 80000001 1 faf30004c0de
ovr 0bad 13579bdf fdb97531 faf300040bad 1
frame 5555 aaaa5555 2 faf300045555
off 3c3c3c3c 1
frame a5a5 76543210 4 faf30004a5a5
cfg 00f 0003
frame 0f0f 6996 2 faf300040f0f
frame f0f0 9669 3 faf30004f0f0
cfg 01f 0001
frame 1111 fedcba98 2 faf300041111
frame 2222 01234567 1 faf300042222
frame 3333 ffff0000 3 faf300043333
ovr 4444 0000ffff ffff0000 faf300044444 1
frame 6666 a0a0a0a0 2 faf300046666
